//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and $(LOG)"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module nabp_tb -f build.f -Mdir obj_dir -o nabp_sim
	./obj_dir/nabp_sim | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
common/nabp_pkg.sv
common/nabp_swap_if.sv
source/nabp_apb_regs.sv
swap_control/nabp_swap_control.sv
source/nabp_state_control.sv
shifter/nabp_shifter.sv
source/nabp_mapper.sv
source/nabp_processing_top.sv
verification/nabp_tb.sv

//--- common/nabp_pkg.sv
package nabp_pkg;

    // sinogram sample width
    parameter int sample_w = 16;

    // rotation offset applied by the shifter
    parameter int shift_base_w = 8;

    // mapper accumulator and pixel address width
    parameter int map_w = 12;

    // angle count field in the control register
    parameter int count_w = 3;

    // per-angle settings as seen by the swap control
    typedef struct packed {
        logic [map_w-1:0]        map_init;
        logic [map_w-1:0]        map_step;
        logic [shift_base_w-1:0] shift_base;
    } angle_fields_t;

    // host writes raw words, the datapath reads fields
    typedef union packed {
        logic [31:0]   raw;
        angle_fields_t fields;
    } angle_cfg_u;

    // processing element states
    typedef enum logic [1:0] {
        ready_s     = 2'd0,
        fill_s      = 2'd1,
        fill_done_s = 2'd2,
        shift_s     = 2'd3
    } proc_state_e;

endpackage

//--- common/nabp_swap_if.sv
`timescale 1ns/1ps

interface nabp_swap_if;
    import nabp_pkg::*;

    // requests are levels, held until acknowledged
    logic next_itr;
    logic swap;

    // acknowledges are single cycle pulses
    logic next_itr_ack;
    logic swap_ack;

    // settings of the angle currently indexed
    angle_cfg_u cfg;

    modport swap_ctrl (
        input  next_itr,
        input  swap,
        output next_itr_ack,
        output swap_ack,
        output cfg
    );

    modport state_ctrl (
        output next_itr,
        output swap,
        input  next_itr_ack,
        input  swap_ack,
        input  cfg
    );

endinterface

//--- shifter/nabp_shifter.sv
`timescale 1ns/1ps

module nabp_shifter #(
    parameter int line_depth = 8
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               fill_kick,
    input  logic                               shift_kick,
    input  logic [nabp_pkg::shift_base_w-1:0]  shift_base,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [nabp_pkg::sample_w-1:0]      in_sample,
    output logic                               fill_done,
    output logic                               shift_done,
    output logic                               out_valid,
    output logic [nabp_pkg::sample_w-1:0]      out_sample
);
    import nabp_pkg::*;

    localparam int ptr_w = (line_depth > 1) ? $clog2(line_depth) : 1;
    localparam logic [ptr_w-1:0] last_pos = ptr_w'(line_depth - 1);

    logic [sample_w-1:0] line_buf [line_depth];
    logic                filling;
    logic                shifting;
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [ptr_w-1:0]    out_cnt;
    logic                accept;

    assign in_ready = filling;
    assign accept   = in_valid && filling;

    // last sample of the line accepted
    assign fill_done = accept && (wr_ptr == last_pos);

    assign out_valid  = shifting;
    assign out_sample = line_buf[rd_ptr];
    assign shift_done = shifting && (out_cnt == last_pos);

    always_ff @(posedge clk)
    begin
        if (accept)
            line_buf[wr_ptr] <= in_sample;
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            filling  <= 1'b0;
            shifting <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            out_cnt  <= '0;
        end
        else
        begin
            // fill side
            if (fill_kick)
            begin
                filling <= 1'b1;
                wr_ptr  <= '0;
            end
            else if (accept)
            begin
                wr_ptr <= wr_ptr + 1'b1;
                if (fill_done)
                    filling <= 1'b0;
            end

            // shift side, starts at the rotated position
            if (shift_kick)
            begin
                shifting <= 1'b1;
                rd_ptr   <= ptr_w'(shift_base % line_depth);
                out_cnt  <= '0;
            end
            else if (shifting)
            begin
                rd_ptr  <= (rd_ptr == last_pos) ? '0 : rd_ptr + 1'b1;
                out_cnt <= out_cnt + 1'b1;
                if (shift_done)
                    shifting <= 1'b0;
            end
        end
    end

endmodule

//--- source/nabp_apb_regs.sv
`timescale 1ns/1ps

module nabp_apb_regs #(
    parameter int max_angles = 4
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [7:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          start,
    output logic [nabp_pkg::count_w-1:0]  angle_count,
    input  logic [nabp_pkg::count_w-1:0]  table_index,
    output nabp_pkg::angle_cfg_u          table_word,
    input  logic                          run_done,
    output logic                          irq
);
    import nabp_pkg::*;

    localparam int idx_w   = (max_angles > 1) ? $clog2(max_angles) : 1;
    localparam int tbl_end = 16 + 4 * max_angles;

    angle_cfg_u       table_mem [max_angles];
    logic             done;
    logic             busy;
    logic             access;
    logic             wr_en;
    logic             sel_ctrl;
    logic             sel_stat;
    logic             sel_tbl;
    logic [5:0]       tbl_word_addr;
    logic [idx_w-1:0] tbl_idx;

    assign access   = psel && penable;
    assign wr_en    = access && pwrite;
    assign sel_ctrl = (paddr == 8'h00);
    assign sel_stat = (paddr == 8'h04);
    assign sel_tbl  = (paddr >= 8'h10) && (paddr < tbl_end) && (paddr[1:0] == 2'b00);

    // word offset into the angle table
    assign tbl_word_addr = paddr[7:2] - 6'd4;
    assign tbl_idx       = tbl_word_addr[idx_w-1:0];

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access && !(sel_ctrl || sel_stat || sel_tbl);
    assign irq     = done;

    always_comb
    begin
        prdata = '0;
        if (sel_ctrl)
            prdata = {28'd0, angle_count, 1'b0};
        else if (sel_stat)
            prdata = {30'd0, busy, done};
        else if (sel_tbl)
            prdata = table_mem[tbl_idx].raw;
    end

    // indices past the table read as zero
    assign table_word = (table_index < max_angles) ? table_mem[table_index[idx_w-1:0]] : '0;

    always_ff @(posedge clk)
    begin
        if (wr_en && sel_tbl)
            table_mem[tbl_idx].raw <= pwdata;
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            start       <= 1'b0;
            angle_count <= '0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            // control is frozen for the length of a run
            if (wr_en && sel_ctrl && !busy)
            begin
                angle_count <= pwdata[3:1];
                if (pwdata[0])
                begin
                    start <= 1'b1;
                    busy  <= 1'b1;
                    done  <= 1'b0;
                end
            end
            if (run_done)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            else if (wr_en && sel_stat && pwdata[0])
                done <= 1'b0;
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset_n) penable |-> psel
    );

endmodule

//--- source/nabp_mapper.sv
`timescale 1ns/1ps

module nabp_mapper (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [nabp_pkg::map_w-1:0]     map_init,
    input  logic [nabp_pkg::map_w-1:0]     map_step,
    input  logic                           map_load,
    input  logic                           out_valid,
    input  logic [nabp_pkg::sample_w-1:0]  out_sample,
    output logic                           pix_valid,
    output logic [nabp_pkg::map_w-1:0]     pix_addr,
    output logic [nabp_pkg::sample_w-1:0]  pix_sample
);
    import nabp_pkg::*;

    logic [map_w-1:0] accu;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            pix_valid <= 1'b0;
        else
            pix_valid <= out_valid;
    end

    // address and sample ride along with pix_valid
    always_ff @(posedge clk)
    begin
        if (out_valid)
        begin
            pix_addr   <= accu;
            pix_sample <= out_sample;
        end
    end

    // wraps modulo 2^map_w
    always_ff @(posedge clk)
    begin
        if (map_load)
            accu <= map_init;
        else if (out_valid)
            accu <= accu + map_step;
    end

endmodule

//--- source/nabp_processing_top.sv
`timescale 1ns/1ps

module nabp_processing_top #(
    parameter int line_depth = 8,
    parameter int max_angles = 4
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [7:0]                     paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [nabp_pkg::sample_w-1:0]  in_sample,
    output logic                           pix_valid,
    output logic [nabp_pkg::map_w-1:0]     pix_addr,
    output logic [nabp_pkg::sample_w-1:0]  pix_sample,
    output logic                           irq
);
    import nabp_pkg::*;

    logic                    start;
    logic [count_w-1:0]      angle_count;
    logic [count_w-1:0]      table_index;
    angle_cfg_u              table_word;
    logic                    run_done;
    logic                    fill_kick;
    logic                    shift_kick;
    logic                    fill_done;
    logic                    shift_done;
    logic [shift_base_w-1:0] shift_base;
    logic [map_w-1:0]        map_init;
    logic [map_w-1:0]        map_step;
    logic                    map_load;
    logic                    out_valid;
    logic [sample_w-1:0]     out_sample;

    nabp_swap_if swap_if ();

    nabp_apb_regs #(.max_angles(max_angles)) u_apb_regs (
        .clk, .reset_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .start, .angle_count, .table_index,
        .table_word, .run_done, .irq
    );

    nabp_swap_control #(.max_angles(max_angles)) u_swap_control (
        .clk, .reset_n, .start, .angle_count, .table_index, .table_word,
        .run_done, .swap_if(swap_if.swap_ctrl)
    );

    nabp_state_control u_state_control (
        .clk, .reset_n, .swap_if(swap_if.state_ctrl), .fill_kick, .shift_kick,
        .fill_done, .shift_done, .shift_base, .map_init, .map_step, .map_load
    );

    nabp_shifter #(.line_depth(line_depth)) u_shifter (
        .clk, .reset_n, .fill_kick, .shift_kick, .shift_base, .in_valid,
        .in_ready, .in_sample, .fill_done, .shift_done, .out_valid, .out_sample
    );

    nabp_mapper u_mapper (
        .clk, .reset_n, .map_init, .map_step, .map_load, .out_valid,
        .out_sample, .pix_valid, .pix_addr, .pix_sample
    );

endmodule

//--- source/nabp_state_control.sv
`timescale 1ns/1ps

module nabp_state_control (
    input  logic                               clk,
    input  logic                               reset_n,
    nabp_swap_if.state_ctrl                    swap_if,
    output logic                               fill_kick,
    output logic                               shift_kick,
    input  logic                               fill_done,
    input  logic                               shift_done,
    output logic [nabp_pkg::shift_base_w-1:0]  shift_base,
    output logic [nabp_pkg::map_w-1:0]         map_init,
    output logic [nabp_pkg::map_w-1:0]         map_step,
    output logic                               map_load
);
    import nabp_pkg::*;

    proc_state_e state;
    proc_state_e next_state;

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (swap_if.next_itr_ack)
                    next_state = fill_s;
            fill_s:
                if (fill_done)
                    next_state = fill_done_s;
            fill_done_s:
                if (swap_if.swap_ack)
                    next_state = shift_s;
            shift_s:
                if (shift_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state            <= ready_s;
            swap_if.next_itr <= 1'b0;
        end
        else
        begin
            state            <= next_state;
            // request follows the state into ready and drops after the ack
            swap_if.next_itr <= (next_state == ready_s);
        end
    end

    // settings held for the whole angle
    always_ff @(posedge clk)
    begin
        if (state == ready_s)
        begin
            shift_base <= swap_if.cfg.fields.shift_base;
            map_step   <= swap_if.cfg.fields.map_step;
        end
    end

    assign swap_if.swap = (state == fill_done_s);

    // kicks fire on entry into fill and shift
    assign fill_kick  = (state == ready_s) && (next_state == fill_s);
    assign shift_kick = (state == fill_done_s) && (next_state == shift_s);

    // read once at load time, cfg still shows this angle then
    assign map_init = swap_if.cfg.fields.map_init;
    assign map_load = shift_kick;

    a_fill_done_in_fill: assert property (
        @(posedge clk) disable iff (reset_n) fill_done |-> (state == fill_s)
    );

endmodule

//--- swap_control/nabp_swap_control.sv
`timescale 1ns/1ps

module nabp_swap_control #(
    parameter int max_angles = 4
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start,
    input  logic [nabp_pkg::count_w-1:0]  angle_count,
    output logic [nabp_pkg::count_w-1:0]  table_index,
    input  nabp_pkg::angle_cfg_u          table_word,
    output logic                          run_done,
    nabp_swap_if.swap_ctrl                swap_if
);
    import nabp_pkg::*;

    logic [count_w-1:0] angle_idx;
    logic               busy;
    logic               angles_left;

    // table bounds the count as well as the host setting
    assign angles_left = (angle_idx < angle_count) && (angle_idx < max_angles);

    assign table_index = angle_idx;

    // index moves on swap ack, so this is the next angle while shifting
    assign swap_if.cfg = table_word;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            angle_idx            <= '0;
            busy                 <= 1'b0;
            run_done             <= 1'b0;
            swap_if.next_itr_ack <= 1'b0;
            swap_if.swap_ack     <= 1'b0;
        end
        else
        begin
            run_done             <= 1'b0;
            swap_if.next_itr_ack <= 1'b0;
            swap_if.swap_ack     <= 1'b0;

            if (start)
            begin
                busy      <= 1'b1;
                angle_idx <= '0;
            end
            else if (busy)
            begin
                // one ack per request a cycle after it is seen
                if (swap_if.next_itr && !swap_if.next_itr_ack)
                begin
                    if (angles_left)
                        swap_if.next_itr_ack <= 1'b1;
                    else
                    begin
                        run_done <= 1'b1;
                        busy     <= 1'b0;
                    end
                end

                if (swap_if.swap && !swap_if.swap_ack)
                    swap_if.swap_ack <= 1'b1;

                if (swap_if.swap_ack)
                    angle_idx <= angle_idx + 1'b1;
            end
        end
    end

    a_acks_exclusive: assert property (
        @(posedge clk) disable iff (reset_n) !(swap_if.next_itr_ack && swap_if.swap_ack)
    );

endmodule

//--- verification/nabp_tb.sv
`timescale 1ns/1ps

module nabp_tb;
    import nabp_pkg::*;

    localparam int line_depth   = 8;
    localparam int max_angles   = 4;
    localparam int first_count  = 3;
    localparam int second_count = 4;
    // fill with random gaps, shift, handshakes, plus APB traffic around each run
    localparam int watchdog_cycles = (first_count + second_count) * (8 * line_depth + 24) + 512;

    logic                clk = 1'b0;
    logic                reset_n;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [7:0]          paddr;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    logic                in_valid;
    logic                in_ready;
    logic [sample_w-1:0] in_sample;
    logic                pix_valid;
    logic [map_w-1:0]    pix_addr;
    logic [sample_w-1:0] pix_sample;
    logic                irq;

    // reference model state
    angle_cfg_u          tbl [max_angles];
    logic [sample_w-1:0] fill_q [$];
    int                  acc_cnt = 0;
    int                  pix_cnt = 0;
    int                  base_acc = 0;
    int                  base_pix = 0;
    int                  acc_limit = 0;
    int                  pix_limit = 0;
    logic                pending = 1'b0;
    logic                prev_valid = 1'b0;

    always #2 clk = ~clk;

    nabp_processing_top #(.line_depth(line_depth), .max_angles(max_angles)) dut0 (
        .clk, .reset_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .in_valid, .in_ready, .in_sample, .pix_valid,
        .pix_addr, .pix_sample, .irq
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        // sample inside the access phase, ahead of its closing edge
        #1;
        data    = prdata;
        err     = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // k-th output of an angle comes from position (offset + k) mod depth
    function automatic logic [sample_w-1:0] expected_sample(input int idx);
        int ang;
        int k;
        int pos;

        ang = (idx - base_pix) / line_depth;
        k   = (idx - base_pix) % line_depth;
        pos = (int'(tbl[ang].fields.shift_base) + k) % line_depth;
        return fill_q[base_acc + ang * line_depth + pos];
    endfunction

    function automatic logic [map_w-1:0] expected_addr(input int idx);
        int ang;
        int k;

        ang = (idx - base_pix) / line_depth;
        k   = (idx - base_pix) % line_depth;
        return map_w'(int'(tbl[ang].fields.map_init) + k * int'(tbl[ang].fields.map_step));
    endfunction

    task automatic load_table();
        logic [31:0] rd_data;
        logic        rd_err;

        for (int i = 0; i < max_angles; i++)
        begin
            tbl[i].raw = $urandom;
            apb_write(8'(16 + 4 * i), tbl[i].raw);
        end
        for (int i = 0; i < max_angles; i++)
        begin
            apb_read(8'(16 + 4 * i), rd_data, rd_err);
            assert (rd_data == tbl[i].raw && !rd_err)
            else fail_run($sformatf("Mismatch at %0t: table word %0d read %h, expected %h",
                                    $time, i, rd_data, tbl[i].raw));
        end
    endtask

    task automatic run_angles(input int count);
        logic [31:0] rd_data;
        logic        rd_err;

        load_table();
        base_acc  = acc_cnt;
        base_pix  = pix_cnt;
        acc_limit = acc_cnt + count * line_depth;
        pix_limit = pix_cnt + count * line_depth;

        apb_write(8'h00, 32'((count << 1) | 1));
        apb_read(8'h04, rd_data, rd_err);
        assert (rd_data[1] && !rd_err)
        else fail_run($sformatf("Mismatch at %0t: status %h err %b, busy expected",
                                $time, rd_data, rd_err));

        while (!irq)
            @(negedge clk);
        apb_read(8'h04, rd_data, rd_err);
        assert (rd_data[1:0] == 2'b01 && !rd_err)
        else fail_run($sformatf("Mismatch at %0t: status %h after run, expected done only",
                                $time, rd_data));

        // monitor catches any late output during this wait
        repeat (2 * line_depth) @(negedge clk);
        assert (pix_cnt == pix_limit)
        else fail_run($sformatf("Mismatch at %0t: %0d outputs, expected %0d",
                                $time, pix_cnt - base_pix, pix_limit - base_pix));

        apb_write(8'h04, 32'd1);
        assert (!irq)
        else fail_run($sformatf("Mismatch at %0t: irq still high after done was cleared",
                                $time));
    endtask

    // stream source with random valid gaps
    // pending marks a transfer at the next rising edge
    always @(negedge clk)
    begin
        if (reset_n == 1'b0)
        begin
            if (pending)
            begin
                fill_q.push_back(in_sample);
                acc_cnt++;
                in_sample = sample_w'($urandom);
            end
            in_valid = ($urandom % 4) != 0;
            pending  = in_valid && in_ready;
        end
        else
        begin
            in_valid = 1'b0;
            pending  = 1'b0;
        end
    end

    // output monitor
    always @(negedge clk)
    begin
        if (reset_n == 1'b0)
        begin
            if (pix_valid != prev_valid)
                assert (pix_cnt % line_depth == 0)
                else fail_run($sformatf("Mismatch at %0t: output line broken after %0d samples",
                                        $time, pix_cnt));
            if (pix_valid)
            begin
                assert (pix_cnt < pix_limit)
                else fail_run($sformatf("Mismatch at %0t: output after the last angle",
                                        $time));
                assert (pix_sample == expected_sample(pix_cnt))
                else fail_run($sformatf("Mismatch at %0t: pix_sample %h, expected %h",
                                        $time, pix_sample, expected_sample(pix_cnt)));
                assert (pix_addr == expected_addr(pix_cnt))
                else fail_run($sformatf("Mismatch at %0t: pix_addr %h, expected %h",
                                        $time, pix_addr, expected_addr(pix_cnt)));
                pix_cnt++;
            end
            prev_valid = pix_valid;
        end
    end

    // in_ready only while a line is still missing and the previous one went out
    a_ready_only_in_fill: assert property (
        @(posedge clk) disable iff (reset_n)
        in_ready |-> (acc_cnt < acc_limit) && (pix_cnt == acc_cnt - acc_cnt % line_depth)
    ) else fail_run($sformatf("Mismatch at %0t: in_ready high outside a fill phase", $time));

    a_irq_after_last_angle: assert property (
        @(posedge clk) disable iff (reset_n)
        $rose(irq) |-> (pix_cnt == pix_limit) && (acc_cnt == acc_limit)
    ) else fail_run($sformatf("Mismatch at %0t: irq rose before all angles finished", $time));

    a_quiet_while_irq: assert property (
        @(posedge clk) disable iff (reset_n)
        irq |-> !pix_valid && !in_ready
    ) else fail_run($sformatf("Mismatch at %0t: stream active while irq was high", $time));

    a_pready_high: assert property (
        @(posedge clk) disable iff (reset_n)
        pready
    ) else fail_run($sformatf("Mismatch at %0t: pready low, expected high", $time));

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_run($sformatf("Timeout, run not complete after %0d cycles", watchdog_cycles));
    end

    initial
    begin
        logic [31:0] rd_data;
        logic        rd_err;

        void'($urandom(50077));
        reset_n   = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        in_valid  = 1'b0;
        in_sample = sample_w'($urandom);

        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (!in_ready && !pix_valid && !irq)
        else fail_run($sformatf("Mismatch at %0t: in_ready %b pix_valid %b irq %b, expected low",
                                $time, in_ready, pix_valid, irq));
        reset_n = 1'b0;

        apb_read(8'h08, rd_data, rd_err);
        assert (rd_err)
        else fail_run($sformatf("Mismatch at %0t: pslverr low on unmapped address 0x08",
                                $time));

        run_angles(first_count);
        run_angles(second_count);

        $display("Test passed");
        $finish;
    end

endmodule
